/* fixed_point_pkg.sv */
`default_nettype none

package fixed_point_pkg;

  // Number format.
  localparam int DEFAULT_BIT_WIDTH  = 16;  // Total sample width.
  localparam int DEFAULT_DECIMAL_PT = 8;   // Fraction bits, Q8.8.

  // Butterfly FSM.
  typedef enum logic [1:0] {
    bf_idle,  // Waiting for operands.
    bf_calc,  // Forming W*b.
    bf_done   // Holding c and d.
  } bfly_state_e;

endpackage

`default_nettype wire

/* fft_pkg.sv */
`default_nettype none

package fft_pkg;

  localparam int DEFAULT_N_SAMPLES = 8;

  // How a butterfly applies its twiddle to b.
  typedef enum logic [2:0] {
    tw_general,    // Full complex multiply.
    tw_one,        // W = 1.
    tw_minus_one,  // W = -1.
    tw_minus_j,    // W = -j.
    tw_plus_j      // W = +j.
  } twiddle_kind_e;

  function automatic int stage_count(input int n_samples);
    return $clog2(n_samples);
  endfunction

  // Lower sample index of butterfly b in a stage.
  function automatic int pair_low(input int stage, input int b);
    int half;
    half = 1 << stage;
    return (b / half) * (2 * half) + (b % half);
  endfunction

  function automatic int pair_high(input int stage, input int b);
    return pair_low(stage, b) + (1 << stage);
  endfunction

  function automatic int bit_reverse(input int idx, input int n_bits);
    int rev;
    rev = 0;
    for (int i = 0; i < n_bits; i++) begin
      rev = (rev << 1) | ((idx >> i) & 1);
    end
    return rev;
  endfunction

  function automatic int twiddle_index(input int stage, input int b, input int n_samples);
    return (b % (1 << stage)) * (n_samples / (1 << (stage + 1)));
  endfunction

  function automatic twiddle_kind_e twiddle_kind(input int k, input int n_samples);
    if (k == 0) return tw_one;
    if (k == n_samples / 2) return tw_minus_one;
    if (k == n_samples / 4) return tw_minus_j;
    if (k == 3 * n_samples / 4) return tw_plus_j;
    return tw_general;
  endfunction

endpackage

`default_nettype wire

/* fft_crossbar.sv */
`default_nettype none

module fft_crossbar #(
  parameter int BIT_WIDTH = fixed_point_pkg::DEFAULT_BIT_WIDTH,
  parameter int N_SAMPLES = fft_pkg::DEFAULT_N_SAMPLES,
  parameter int STAGE_FFT = 0,
  parameter bit FRONT     = 1'b1
) (
  input  logic [BIT_WIDTH-1:0] recv_real [N_SAMPLES],
  input  logic [BIT_WIDTH-1:0] recv_imag [N_SAMPLES],
  input  logic                 recv_val,
  output logic                 recv_rdy,

  output logic [BIT_WIDTH-1:0] send_real [N_SAMPLES],
  output logic [BIT_WIDTH-1:0] send_imag [N_SAMPLES],
  output logic                 send_val,
  input  logic                 send_rdy
);

  import fft_pkg::*;

  localparam int LOG_N = stage_count(N_SAMPLES);

  // One transfer moves every lane at once.
  assign send_val = recv_val;
  assign recv_rdy = send_rdy;

  for (genvar b = 0; b < N_SAMPLES / 2; b++) begin : g_pair
    localparam int LO = pair_low(STAGE_FFT, b);
    localparam int HI = pair_high(STAGE_FFT, b);

    if (FRONT) begin : g_front
      // Stage 0 sees natural order and reads through the bit reversal.
      localparam int SRC_LO = (STAGE_FFT == 0) ? bit_reverse(LO, LOG_N) : LO;
      localparam int SRC_HI = (STAGE_FFT == 0) ? bit_reverse(HI, LOG_N) : HI;

      assign send_real[2*b]   = recv_real[SRC_LO];
      assign send_imag[2*b]   = recv_imag[SRC_LO];
      assign send_real[2*b+1] = recv_real[SRC_HI];
      assign send_imag[2*b+1] = recv_imag[SRC_HI];
    end else begin : g_back
      assign send_real[LO] = recv_real[2*b];  // c goes back to the low index.
      assign send_imag[LO] = recv_imag[2*b];
      assign send_real[HI] = recv_real[2*b+1];
      assign send_imag[HI] = recv_imag[2*b+1];
    end
  end

endmodule

`default_nettype wire

/* twiddle_generator.sv */
`default_nettype none

module twiddle_generator #(
  parameter int BIT_WIDTH = fixed_point_pkg::DEFAULT_BIT_WIDTH,
  parameter int N_SAMPLES = fft_pkg::DEFAULT_N_SAMPLES,
  parameter int STAGE_FFT = 0
) (
  input  logic [BIT_WIDTH-1:0] sine_wave    [N_SAMPLES],
  output logic [BIT_WIDTH-1:0] twiddle_real [N_SAMPLES/2],
  output logic [BIT_WIDTH-1:0] twiddle_imag [N_SAMPLES/2]
);

  import fft_pkg::*;

  // Quarter period offset turns the sine table into a cosine table.
  localparam int QUARTER = N_SAMPLES / 4;

  for (genvar b = 0; b < N_SAMPLES / 2; b++) begin : g_tw
    localparam int K      = twiddle_index(STAGE_FFT, b, N_SAMPLES);
    localparam int COS_IX = (K + QUARTER) % N_SAMPLES;

    logic [BIT_WIDTH-1:0] sin_k;
    logic [BIT_WIDTH-1:0] cos_k;

    assign sin_k = sine_wave[K];
    assign cos_k = sine_wave[COS_IX];

    // W_k = cos - j*sin.
    assign twiddle_real[b] = cos_k;
    assign twiddle_imag[b] = -sin_k;  // Wraps for the most negative code.
  end

endmodule

`default_nettype wire

/* fixed_point_butterfly.sv */
`default_nettype none

module fixed_point_butterfly #(
  parameter int                     BIT_WIDTH  = fixed_point_pkg::DEFAULT_BIT_WIDTH,
  parameter int                     DECIMAL_PT = fixed_point_pkg::DEFAULT_DECIMAL_PT,
  parameter fft_pkg::twiddle_kind_e KIND       = fft_pkg::tw_general
) (
  input  logic                 clk,
  input  logic                 rst,

  input  logic [BIT_WIDTH-1:0] a_real,
  input  logic [BIT_WIDTH-1:0] a_imag,
  input  logic [BIT_WIDTH-1:0] b_real,
  input  logic [BIT_WIDTH-1:0] b_imag,
  input  logic [BIT_WIDTH-1:0] w_real,
  input  logic [BIT_WIDTH-1:0] w_imag,
  input  logic                 recv_val,
  output logic                 recv_rdy,

  output logic [BIT_WIDTH-1:0] c_real,
  output logic [BIT_WIDTH-1:0] c_imag,
  output logic [BIT_WIDTH-1:0] d_real,
  output logic [BIT_WIDTH-1:0] d_imag,
  output logic                 send_val,
  input  logic                 send_rdy
);

  import fixed_point_pkg::*;
  import fft_pkg::*;

  localparam int PW = 2 * BIT_WIDTH;  // Full product width.
  localparam int CW = $clog2(BIT_WIDTH);

  bfly_state_e state;
  logic [CW-1:0] count;
  logic last_bit;
  logic accept;

  logic [BIT_WIDTH-1:0] a_real_q;
  logic [BIT_WIDTH-1:0] a_imag_q;
  logic [BIT_WIDTH-1:0] b_real_q;
  logic [BIT_WIDTH-1:0] b_imag_q;
  logic [PW-1:0] br_sh;  // Multiplicands, shift left.
  logic [PW-1:0] bi_sh;
  logic [BIT_WIDTH-1:0] wr_sh;  // Multipliers, shift right.
  logic [BIT_WIDTH-1:0] wi_sh;
  logic [PW-1:0] p_rr;
  logic [PW-1:0] p_ii;
  logic [PW-1:0] p_ri;
  logic [PW-1:0] p_ir;
  logic [BIT_WIDTH-1:0] wb_real;
  logic [BIT_WIDTH-1:0] wb_imag;

  // Partial product for one multiplier bit; the sign bit weighs negative.
  function automatic logic [PW-1:0] term(input logic [PW-1:0] mcand, input logic w_bit,
                                         input logic neg);
    if (!w_bit) return '0;
    return neg ? -mcand : mcand;
  endfunction

  assign recv_rdy = (state == bf_idle);
  assign send_val = (state == bf_done);
  assign accept   = recv_val && recv_rdy;
  assign last_bit = (count == CW'(BIT_WIDTH - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= bf_idle;
      count <= '0;
    end else begin
      case (state)
        bf_idle: begin
          if (recv_val) state <= bf_calc;
          count <= '0;
        end
        bf_calc: begin
          count <= count + 1'b1;
          if (KIND != tw_general || last_bit) state <= bf_done;
        end
        bf_done: if (send_rdy) state <= bf_idle;
        default: state <= bf_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      a_real_q <= a_real;
      a_imag_q <= a_imag;
      b_real_q <= b_real;
      b_imag_q <= b_imag;
      br_sh    <= {{BIT_WIDTH{b_real[BIT_WIDTH-1]}}, b_real};
      bi_sh    <= {{BIT_WIDTH{b_imag[BIT_WIDTH-1]}}, b_imag};
      wr_sh    <= w_real;
      wi_sh    <= w_imag;
      p_rr     <= '0;
      p_ii     <= '0;
      p_ri     <= '0;
      p_ir     <= '0;
    end else if (state == bf_calc) begin
      p_rr  <= p_rr + term(br_sh, wr_sh[0], last_bit);
      p_ii  <= p_ii + term(bi_sh, wi_sh[0], last_bit);
      p_ri  <= p_ri + term(br_sh, wi_sh[0], last_bit);
      p_ir  <= p_ir + term(bi_sh, wr_sh[0], last_bit);
      br_sh <= br_sh << 1;
      bi_sh <= bi_sh << 1;
      wr_sh <= wr_sh >> 1;
      wi_sh <= wi_sh >> 1;
    end
  end

  // W*b, each product truncated before the sum.
  always_comb begin
    case (KIND)
      tw_one: begin
        wb_real = b_real_q;
        wb_imag = b_imag_q;
      end
      tw_minus_one: begin
        wb_real = -b_real_q;
        wb_imag = -b_imag_q;
      end
      tw_minus_j: begin
        wb_real = b_imag_q;
        wb_imag = -b_real_q;
      end
      tw_plus_j: begin
        wb_real = -b_imag_q;
        wb_imag = b_real_q;
      end
      default: begin
        wb_real = p_rr[DECIMAL_PT +: BIT_WIDTH] - p_ii[DECIMAL_PT +: BIT_WIDTH];
        wb_imag = p_ri[DECIMAL_PT +: BIT_WIDTH] + p_ir[DECIMAL_PT +: BIT_WIDTH];
      end
    endcase
  end

  assign c_real = a_real_q + wb_real;
  assign c_imag = a_imag_q + wb_imag;
  assign d_real = a_real_q - wb_real;
  assign d_imag = a_imag_q - wb_imag;

endmodule

`default_nettype wire

/* fft_stage.sv */
`default_nettype none

module fft_stage #(
  parameter int BIT_WIDTH  = fixed_point_pkg::DEFAULT_BIT_WIDTH,
  parameter int DECIMAL_PT = fixed_point_pkg::DEFAULT_DECIMAL_PT,
  parameter int N_SAMPLES  = fft_pkg::DEFAULT_N_SAMPLES,
  parameter int STAGE_FFT  = 0
) (
  input  logic                 clk,
  input  logic                 rst,

  input  logic [BIT_WIDTH-1:0] recv_real [N_SAMPLES],
  input  logic [BIT_WIDTH-1:0] recv_imag [N_SAMPLES],
  input  logic                 recv_val,
  output logic                 recv_rdy,

  output logic [BIT_WIDTH-1:0] send_real [N_SAMPLES],
  output logic [BIT_WIDTH-1:0] send_imag [N_SAMPLES],
  output logic                 send_val,
  input  logic                 send_rdy,

  input  logic [BIT_WIDTH-1:0] sine_wave [N_SAMPLES]
);

  import fft_pkg::*;

  localparam int N_BFLY = N_SAMPLES / 2;

  logic [BIT_WIDTH-1:0] pair_real [N_SAMPLES];  // Lanes 2b and 2b+1 feed butterfly b.
  logic [BIT_WIDTH-1:0] pair_imag [N_SAMPLES];
  logic [BIT_WIDTH-1:0] bfly_real [N_SAMPLES];
  logic [BIT_WIDTH-1:0] bfly_imag [N_SAMPLES];
  logic [BIT_WIDTH-1:0] twiddle_real [N_BFLY];
  logic [BIT_WIDTH-1:0] twiddle_imag [N_BFLY];

  logic pair_val;
  logic pair_rdy;
  logic bfly_val;
  logic bfly_rdy;
  logic [N_BFLY-1:0] bf_recv_rdy;
  logic [N_BFLY-1:0] bf_send_val;

  // Butterflies start and release as one group.
  assign pair_rdy = &bf_recv_rdy;
  assign bfly_val = &bf_send_val;

  fft_crossbar #(
    .BIT_WIDTH(BIT_WIDTH),
    .N_SAMPLES(N_SAMPLES),
    .STAGE_FFT(STAGE_FFT),
    .FRONT    (1'b1)
  ) u_xbar_in (
    .recv_real(recv_real),
    .recv_imag(recv_imag),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_real(pair_real),
    .send_imag(pair_imag),
    .send_val (pair_val),
    .send_rdy (pair_rdy)
  );

  twiddle_generator #(
    .BIT_WIDTH(BIT_WIDTH),
    .N_SAMPLES(N_SAMPLES),
    .STAGE_FFT(STAGE_FFT)
  ) u_twiddle (
    .sine_wave   (sine_wave),
    .twiddle_real(twiddle_real),
    .twiddle_imag(twiddle_imag)
  );

  for (genvar b = 0; b < N_BFLY; b++) begin : g_bfly
    localparam twiddle_kind_e KIND = twiddle_kind(twiddle_index(STAGE_FFT, b, N_SAMPLES),
                                                  N_SAMPLES);

    fixed_point_butterfly #(
      .BIT_WIDTH (BIT_WIDTH),
      .DECIMAL_PT(DECIMAL_PT),
      .KIND      (KIND)
    ) u_bfly (
      .clk     (clk),
      .rst     (rst),
      .a_real  (pair_real[2*b]),
      .a_imag  (pair_imag[2*b]),
      .b_real  (pair_real[2*b+1]),
      .b_imag  (pair_imag[2*b+1]),
      .w_real  (twiddle_real[b]),
      .w_imag  (twiddle_imag[b]),
      .recv_val(pair_val && pair_rdy),
      .recv_rdy(bf_recv_rdy[b]),
      .c_real  (bfly_real[2*b]),
      .c_imag  (bfly_imag[2*b]),
      .d_real  (bfly_real[2*b+1]),
      .d_imag  (bfly_imag[2*b+1]),
      .send_val(bf_send_val[b]),
      .send_rdy(bfly_rdy && bfly_val)
    );
  end

  fft_crossbar #(
    .BIT_WIDTH(BIT_WIDTH),
    .N_SAMPLES(N_SAMPLES),
    .STAGE_FFT(STAGE_FFT),
    .FRONT    (1'b0)
  ) u_xbar_out (
    .recv_real(bfly_real),
    .recv_imag(bfly_imag),
    .recv_val (bfly_val),
    .recv_rdy (bfly_rdy),
    .send_real(send_real),
    .send_imag(send_imag),
    .send_val (send_val),
    .send_rdy (send_rdy)
  );

endmodule

`default_nettype wire

/* fft_top.sv */
`default_nettype none

module fft_top #(
  parameter int BIT_WIDTH  = fixed_point_pkg::DEFAULT_BIT_WIDTH,
  parameter int DECIMAL_PT = fixed_point_pkg::DEFAULT_DECIMAL_PT,
  parameter int N_SAMPLES  = fft_pkg::DEFAULT_N_SAMPLES
) (
  input  logic                 clk,
  input  logic                 rst,

  input  logic [BIT_WIDTH-1:0] recv_real [N_SAMPLES],
  input  logic [BIT_WIDTH-1:0] recv_imag [N_SAMPLES],
  input  logic                 recv_val,
  output logic                 recv_rdy,

  input  logic [BIT_WIDTH-1:0] sine_wave [N_SAMPLES],

  output logic [BIT_WIDTH-1:0] send_real [N_SAMPLES],
  output logic [BIT_WIDTH-1:0] send_imag [N_SAMPLES],
  output logic                 send_val,
  input  logic                 send_rdy
);

  import fft_pkg::*;

  localparam int STAGES = stage_count(N_SAMPLES);

  // Link s is the input of stage s, link STAGES the output.
  logic [BIT_WIDTH-1:0] link_real [STAGES+1][N_SAMPLES];
  logic [BIT_WIDTH-1:0] link_imag [STAGES+1][N_SAMPLES];
  logic                 link_val  [STAGES+1];
  logic                 link_rdy  [STAGES+1];

  assign link_real[0] = recv_real;
  assign link_imag[0] = recv_imag;
  assign link_val[0]  = recv_val;
  assign recv_rdy     = link_rdy[0];

  assign send_real        = link_real[STAGES];
  assign send_imag        = link_imag[STAGES];
  assign send_val         = link_val[STAGES];
  assign link_rdy[STAGES] = send_rdy;

  for (genvar s = 0; s < STAGES; s++) begin : g_stage
    fft_stage #(
      .BIT_WIDTH (BIT_WIDTH),
      .DECIMAL_PT(DECIMAL_PT),
      .N_SAMPLES (N_SAMPLES),
      .STAGE_FFT (s)
    ) u_stage (
      .clk      (clk),
      .rst      (rst),
      .recv_real(link_real[s]),
      .recv_imag(link_imag[s]),
      .recv_val (link_val[s]),
      .recv_rdy (link_rdy[s]),
      .send_real(link_real[s+1]),
      .send_imag(link_imag[s+1]),
      .send_val (link_val[s+1]),
      .send_rdy (link_rdy[s+1]),
      .sine_wave(sine_wave)  // Same table for every stage.
    );
  end

endmodule

`default_nettype wire

/* tb_fft_top.sv */
`default_nettype none

module tb_fft_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int BIT_WIDTH      = 16;
  localparam int DECIMAL_PT     = 8;
  localparam int N_SAMPLES      = 8;
  localparam int N_STAGES       = $clog2(N_SAMPLES);
  localparam int N_TRANSFORMS   = 4;  // Transforms held in the vectors file.
  localparam int N_ROUNDS       = 3;
  localparam int N_SENDS        = N_TRANSFORMS * N_ROUNDS;
  localparam int VEC_WORDS      = N_SAMPLES + N_TRANSFORMS * 4 * N_SAMPLES;
  localparam int TIMEOUT_CYCLES = N_SENDS * N_STAGES * (BIT_WIDTH + 4) * 4 + 200;
  localparam logic [31:0] SEED  = 32'h5158_c54e;

  logic clk;
  logic rst;
  logic [BIT_WIDTH-1:0] recv_real [N_SAMPLES];
  logic [BIT_WIDTH-1:0] recv_imag [N_SAMPLES];
  logic                 recv_val;
  logic                 recv_rdy;
  logic [BIT_WIDTH-1:0] sine_wave [N_SAMPLES];
  logic [BIT_WIDTH-1:0] send_real [N_SAMPLES];
  logic [BIT_WIDTH-1:0] send_imag [N_SAMPLES];
  logic                 send_val;
  logic                 send_rdy;

  logic [BIT_WIDTH-1:0] vec_mem   [VEC_WORDS];
  logic [BIT_WIDTH-1:0] held_real [N_SAMPLES];  // Output seen during a stall.
  logic [BIT_WIDTH-1:0] held_imag [N_SAMPLES];
  logic stalled;
  bit   stall_mode;
  int   scoreboard [$];  // Transform indices in send order.
  int   mismatch_count = 0;
  int   error_count = 0;
  int   sent_count = 0;
  int   recv_count = 0;
  int   cycle_count = 0;

  fft_top #(
    .BIT_WIDTH (BIT_WIDTH),
    .DECIMAL_PT(DECIMAL_PT),
    .N_SAMPLES (N_SAMPLES)
  ) u_dut (
    .clk      (clk),
    .rst      (rst),
    .recv_real(recv_real),
    .recv_imag(recv_imag),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .sine_wave(sine_wave),
    .send_real(send_real),
    .send_imag(send_imag),
    .send_val (send_val),
    .send_rdy (send_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // Field 0 input real, 1 input imag, 2 expected real, 3 expected imag.
  function automatic logic [BIT_WIDTH-1:0] vector_word(input int idx, input int field,
                                                       input int lane);
    return vec_mem[N_SAMPLES + (idx * 4 + field) * N_SAMPLES + lane];
  endfunction

  task automatic print_summary();
    $display("Errors: %0d mismatches, %0d other; transforms in %0d, out %0d, planned %0d",
             mismatch_count, error_count, sent_count, recv_count, N_SENDS);
  endtask

  task automatic send_transform(input int idx, input bit with_gap);
    int  gap;
    bit  accepted;
    accepted = 1'b0;
    if (with_gap) begin
      gap = $urandom % 4;
      if (gap > 0) begin
        recv_val = 1'b0;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
    end
    for (int i = 0; i < N_SAMPLES; i++) begin
      recv_real[i] = vector_word(idx, 0, i);
      recv_imag[i] = vector_word(idx, 1, i);
    end
    recv_val = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      if (recv_rdy === 1'b1) begin  // Taken at the next rising edge.
        accepted = 1'b1;
        scoreboard.push_back(idx);
        sent_count++;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_output();
    int idx;
    if (scoreboard.size() == 0) begin
      error_count++;
      $display("ERROR t=%0t output transfer with no transform outstanding", $time);
    end else begin
      idx = scoreboard.pop_front();
      for (int i = 0; i < N_SAMPLES; i++) begin
        if (send_real[i] !== vector_word(idx, 2, i)) begin
          mismatch_count++;
          $display("MISMATCH t=%0t send_real[%0d] transform %0d expected %h got %h",
                   $time, i, idx, vector_word(idx, 2, i), send_real[i]);
        end
        if (send_imag[i] !== vector_word(idx, 3, i)) begin
          mismatch_count++;
          $display("MISMATCH t=%0t send_imag[%0d] transform %0d expected %h got %h",
                   $time, i, idx, vector_word(idx, 3, i), send_imag[i]);
        end
      end
      recv_count++;
    end
  endtask

  // Back-pressure on the output.
  always @(posedge clk) begin
    if (stall_mode) send_rdy <= #1 (($urandom % 3) != 0);
    else send_rdy <= #1 1'b1;
  end

  // Outputs are sampled mid-cycle, where they are settled.
  always @(negedge clk) begin
    if (rst === 1'b0) begin
      if (stalled) begin
        if (send_val !== 1'b1) begin
          error_count++;
          $display("ERROR t=%0t send_val dropped before the output was taken", $time);
        end
        for (int i = 0; i < N_SAMPLES; i++) begin
          if (send_real[i] !== held_real[i]) begin
            mismatch_count++;
            $display("MISMATCH t=%0t send_real[%0d] expected %h (held) got %h",
                     $time, i, held_real[i], send_real[i]);
          end
          if (send_imag[i] !== held_imag[i]) begin
            mismatch_count++;
            $display("MISMATCH t=%0t send_imag[%0d] expected %h (held) got %h",
                     $time, i, held_imag[i], send_imag[i]);
          end
        end
      end
      if (send_val === 1'b1 && send_rdy === 1'b1) check_output();
      stalled = (send_val === 1'b1) && (send_rdy !== 1'b1);
      for (int i = 0; i < N_SAMPLES; i++) begin
        held_real[i] = send_real[i];
        held_imag[i] = send_imag[i];
      end
    end
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    error_count++;
    $display("ERROR t=%0t run timed out after %0d cycles", $time, cycle_count);
    print_summary();
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int seed;
    int discard;
    rst        = 1'b1;
    recv_val   = 1'b0;
    send_rdy   = 1'b0;
    stall_mode = 1'b1;
    stalled    = 1'b0;
    for (int i = 0; i < N_SAMPLES; i++) begin
      recv_real[i] = '0;
      recv_imag[i] = '0;
      sine_wave[i] = '0;
    end
    seed = SEED;
    discard = $urandom(seed);
    $readmemh("fft_vectors.txt", vec_mem);
    if ($isunknown(vec_mem[VEC_WORDS-1])) begin
      error_count++;
      $display("ERROR fft_vectors.txt is missing or shorter than expected");
    end
    for (int i = 0; i < N_SAMPLES; i++) sine_wave[i] = vec_mem[i];

    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    if (send_val !== 1'b0) begin
      mismatch_count++;
      $display("MISMATCH t=%0t send_val expected 0 got %b", $time, send_val);
    end
    if (recv_rdy !== 1'b1) begin
      mismatch_count++;
      $display("MISMATCH t=%0t recv_rdy expected 1 got %b", $time, recv_rdy);
    end
    @(posedge clk);
    #1;

    // Gaps and stalls, then back-to-back, then back-to-back with stalls.
    for (int round = 0; round < N_ROUNDS; round++) begin
      stall_mode = (round != 1);
      for (int t = 0; t < N_TRANSFORMS; t++) send_transform(t, round == 0);
    end
    recv_val = 1'b0;

    while (recv_count < sent_count) @(posedge clk);
    repeat (4 * (BIT_WIDTH + 4)) @(posedge clk);  // Room for a stray extra output.

    print_summary();
    if (mismatch_count == 0 && error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fft_vectors.txt */
// 16-bit Q8.8 two's complement words. First row: sine table sin(2*pi*i/8), i = 0..7.
// Per transform: input real, input imag, expected real, expected imag, lanes 0..7.
0000 00B5 0100 00B5 0000 FF4B FF00 FF4B
// Impulse of 1.0 at sample 0.
0100 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0100 0100 0100 0100 0100 0100 0100 0100
0000 0000 0000 0000 0000 0000 0000 0000
// Constant 0.125 - j0.0625 on every sample.
0020 0020 0020 0020 0020 0020 0020 0020
FFF0 FFF0 FFF0 FFF0 FFF0 FFF0 FFF0 FFF0
0100 0000 0000 0000 0000 0000 0000 0000
FF80 0000 0000 0000 0000 0000 0000 0000
// Random values, small magnitude.
0064 FF38 004B 000A FFDD 0096 FFB0 0028
FFCE 001E 0078 FFA6 003C FFEC 0005 0046
003C FFCA 0064 00A9 003C 022A 0028 FF7F
007D 0097 FFF1 00A4 0091 FD57 FF29 FFB6
// Random values, large magnitude.
04D2 F448 0309 FBA9 0800 FDA8 03E7 0141
F6D7 05DC 0378 FF22 0200 F2FB FC18 09C4
029C 075A F5D3 FDF3 24E8 010A 15F1 ECF1
FA24 1527 0441 E9B0 F6AA D643 EE4D FE42

/* src.f */
fixed_point_pkg.sv
fft_pkg.sv
fft_crossbar.sv
twiddle_generator.sv
fixed_point_butterfly.sv
fft_stage.sv
fft_top.sv
tb_fft_top.sv
